/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_afe_ft601
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build products and the log"

$(SIM): $(FILELIST) $(shell cat $(FILELIST)) afe_ft601_cases.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation gave no verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* afe_ft601_cases.txt */
# cmd args: case <name> | s <ch0 hex> <ch1 hex> | stall <n> | rstall <max> | idle <n>
#           words <n> | hold | fill | release | drain   (counts in decimal)
case order
s 0001 0002
s 0123 0456
s 1fff 2000
s 3fff 0000
s 0abc 3def
s 2222 1111
s 0000 3fff
s 1357 2468
drain
words 8
case mask
stall 2
stall 0
stall 5
s c000 4000
s ffff ffff
s 8001 4002
s 7abc bdef
drain
words 4
case group
s 0010 0020
s 0030 0040
s 0050 0060
s 0070 0080
s 0090 00a0
s 00b0 00c0
idle 200
words 4
s 00d0 00e0
s 00f0 0100
drain
words 8
case backpressure
hold
fill
rstall 7
release
drain
idle 50

/* afe_ft601_top.sv */
`default_nettype none

// adc samples -> pack -> memory buffer -> unpack -> ft601 write bus
module afe_ft601_top (
    input  wire logic                                ui_clk,
    input  wire logic                                rst,
    input  wire logic                                adc_valid,
    input  wire logic [stream_pkg::ADC_WORD_BITS-1:0] adc_ch0,
    input  wire logic [stream_pkg::ADC_WORD_BITS-1:0] adc_ch1,
    output logic                                     adc_ready,
    input  wire logic                                usb_txe_n,
    output logic [stream_pkg::USB_WORD_BITS-1:0]     usb_data,
    output logic [stream_pkg::USB_BE_BITS-1:0]       usb_be,
    output logic                                     usb_wr_n
);

    import stream_pkg::*;

    localparam int PAD_BITS = ADC_WORD_BITS - SAMPLE_BITS; // zeros above each field

    usb_word_t adc_word;

    // input fifo -> packer
    logic      in_valid;
    logic      in_ready;
    usb_word_t in_word;

    // packer -> memory fifo
    logic      pk_valid;
    logic      pk_ready;
    mem_word_t pk_word;

    // memory fifo -> unpacker
    logic      mf_valid;
    logic      mf_ready;
    mem_word_t mf_word;

    // unpacker -> output fifo
    logic      up_valid;
    logic      up_ready;
    usb_word_t up_word;

    // output fifo -> transmitter
    logic      of_valid;
    logic      of_ready;
    usb_word_t of_word;

    ////////////////////////////////////////////////////////////
    // sample formatting, ch1 high half, ch0 low half
    ////////////////////////////////////////////////////////////

    assign adc_word = {{PAD_BITS{1'b0}}, adc_ch1[SAMPLE_BITS-1:0],
                       {PAD_BITS{1'b0}}, adc_ch0[SAMPLE_BITS-1:0]};

    stream_fifo #(.WIDTH(USB_WORD_BITS), .DEPTH(IN_FIFO_DEPTH)) u_in_fifo (
        .ui_clk(ui_clk), .rst(rst),
        .in_valid(adc_valid), .in_data(adc_word), .in_ready(adc_ready),
        .out_valid(in_valid), .out_data(in_word), .out_ready(in_ready)
    );

    bit_packer u_bit_packer (
        .ui_clk(ui_clk), .rst(rst),
        .in_valid(in_valid), .in_data(in_word), .in_ready(in_ready),
        .out_valid(pk_valid), .out_data(pk_word), .out_ready(pk_ready)
    );

    // ddr3 vfifo stand-in
    stream_fifo #(.WIDTH(MEM_WORD_BITS), .DEPTH(MEM_FIFO_DEPTH)) u_mem_fifo (
        .ui_clk(ui_clk), .rst(rst),
        .in_valid(pk_valid), .in_data(pk_word), .in_ready(pk_ready),
        .out_valid(mf_valid), .out_data(mf_word), .out_ready(mf_ready)
    );

    bit_unpacker u_bit_unpacker (
        .ui_clk(ui_clk), .rst(rst),
        .in_valid(mf_valid), .in_data(mf_word), .in_ready(mf_ready),
        .out_valid(up_valid), .out_data(up_word), .out_ready(up_ready)
    );

    stream_fifo #(.WIDTH(USB_WORD_BITS), .DEPTH(IN_FIFO_DEPTH)) u_out_fifo (
        .ui_clk(ui_clk), .rst(rst),
        .in_valid(up_valid), .in_data(up_word), .in_ready(up_ready),
        .out_valid(of_valid), .out_data(of_word), .out_ready(of_ready)
    );

    ft601_tx u_ft601_tx (
        .ui_clk(ui_clk), .rst(rst),
        .in_valid(of_valid), .in_data(of_word), .in_ready(of_ready),
        .usb_txe_n(usb_txe_n), .usb_data(usb_data), .usb_be(usb_be),
        .usb_wr_n(usb_wr_n)
    );

endmodule : afe_ft601_top

`default_nettype wire

/* bit_packer.sv */
`default_nettype none

// four 32-bit words into one 128-bit memory word, lane 0 in the low bits
module bit_packer (
    input  wire logic                 ui_clk,
    input  wire logic                 rst,
    input  wire logic                 in_valid,
    input  wire stream_pkg::usb_word_t in_data,
    output logic                      in_ready,
    output logic                      out_valid,
    output stream_pkg::mem_word_t     out_data,
    input  wire logic                 out_ready
);

    import stream_pkg::*;

    logic [LANE_BITS-1:0] lane_cnt;  // next lane to fill
    mem_word_t            pack_q;    // word under assembly
    logic                 full_q;    // all lanes filled, waiting for taker

    logic take_in;
    logic give_out;

    assign in_ready  = !full_q || out_ready; // next group starts as this one leaves
    assign out_valid = full_q;
    assign out_data  = pack_q;

    assign take_in  = in_valid && in_ready;
    assign give_out = out_valid && out_ready;

    // payload lanes
    always_ff @(posedge ui_clk) begin
        if (take_in) begin
            pack_q[lane_cnt*USB_WORD_BITS +: USB_WORD_BITS] <= in_data;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            lane_cnt <= '0;
            full_q   <= 1'b0;
        end else begin
            if (take_in) begin
                if (lane_cnt == LANE_BITS'(LANES - 1)) begin
                    lane_cnt <= '0;
                    full_q   <= 1'b1; // valid on the fourth word's edge
                end else begin
                    lane_cnt <= lane_cnt + 1'b1;
                end
            end
            if (give_out) begin
                full_q <= 1'b0; // word handed to the memory fifo
            end
        end
    end

    // counter parked at lane 0 while a packed word waits
    a_lane_park: assert property (@(posedge ui_clk) disable iff (rst)
        full_q |-> (lane_cnt == '0));

endmodule : bit_packer

`default_nettype wire

/* bit_unpacker.sv */
`default_nettype none

// one 128-bit memory word out as four 32-bit words, lane 0 first
module bit_unpacker (
    input  wire logic                  ui_clk,
    input  wire logic                  rst,
    input  wire logic                  in_valid,
    input  wire stream_pkg::mem_word_t in_data,
    output logic                       in_ready,
    output logic                       out_valid,
    output stream_pkg::usb_word_t      out_data,
    input  wire logic                  out_ready
);

    import stream_pkg::*;

    mem_word_t            hold_q;   // current memory word
    logic                 full_q;   // hold_q has lanes left
    logic [LANE_BITS-1:0] lane_idx; // lane on the output

    logic last_lane;
    logic take_in;
    logic give_out;

    assign last_lane = (lane_idx == LANE_BITS'(LANES - 1));
    assign give_out  = out_valid && out_ready;

    // idle, or the last lane leaves on this edge
    assign in_ready = !full_q || (last_lane && out_ready);
    assign take_in  = in_valid && in_ready;

    assign out_valid = full_q;
    assign out_data  = hold_q[lane_idx*USB_WORD_BITS +: USB_WORD_BITS];

    always_ff @(posedge ui_clk) begin
        if (take_in) begin
            hold_q <= in_data;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            full_q   <= 1'b0;
            lane_idx <= '0;
        end else if (take_in) begin
            full_q   <= 1'b1; // fresh word, start at lane 0
            lane_idx <= '0;
        end else if (give_out) begin
            if (last_lane) begin
                full_q   <= 1'b0; // word released
                lane_idx <= '0;
            end else begin
                lane_idx <= lane_idx + 1'b1;
            end
        end
    end

endmodule : bit_unpacker

`default_nettype wire

/* build.f */
stream_pkg.sv
stream_fifo.sv
bit_packer.sv
bit_unpacker.sv
ft601_tx.sv
afe_ft601_top.sv
tb_afe_ft601.sv

/* ft601_tx.sv */
`default_nettype none

// ft601 245-mode write side, one word per txe_n window
module ft601_tx (
    input  wire logic                               ui_clk,
    input  wire logic                               rst,
    input  wire logic                               in_valid,
    input  wire stream_pkg::usb_word_t              in_data,
    output logic                                    in_ready,
    input  wire logic                               usb_txe_n,  // low = device has room
    output stream_pkg::usb_word_t                   usb_data,
    output logic [stream_pkg::USB_BE_BITS-1:0]      usb_be,
    output logic                                    usb_wr_n
);

    import stream_pkg::*;

    tx_state_t state_q;
    usb_word_t data_q;  // word driven on the bus

    logic take_in;
    logic bus_xfer;

    assign in_ready = (state_q == TX_IDLE);
    assign take_in  = in_valid && in_ready;

    // wr_n follows txe_n in the same cycle while a word is held
    assign bus_xfer = (state_q == TX_WRITE) && !usb_txe_n;

    assign usb_wr_n = !bus_xfer;
    assign usb_be   = bus_xfer ? '1 : '0; // all bytes valid, 32-bit only
    assign usb_data = data_q;

    always_ff @(posedge ui_clk) begin
        if (take_in) begin
            data_q <= in_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            state_q <= TX_IDLE;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (take_in) begin
                        state_q <= TX_WRITE;
                    end
                end
                TX_WRITE: begin
                    if (bus_xfer) begin
                        state_q <= TX_IDLE; // ready again next cycle
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // parked word does not change under a stalled device
    a_bus_hold: assert property (@(posedge ui_clk) disable iff (rst)
        (state_q == TX_WRITE && usb_wr_n) |=> $stable(usb_data));

endmodule : ft601_tx

`default_nettype wire

/* stream_fifo.sv */
`default_nettype none

// plain circular buffer, valid/ready on both sides
module stream_fifo #(
    parameter int WIDTH = stream_pkg::USB_WORD_BITS,
    parameter int DEPTH = stream_pkg::IN_FIFO_DEPTH
) (
    input  wire logic             ui_clk,
    input  wire logic             rst,
    input  wire logic             in_valid,
    input  wire logic [WIDTH-1:0] in_data,
    output logic                  in_ready,
    output logic                  out_valid,
    output logic      [WIDTH-1:0] out_data,
    input  wire logic             out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH]; // storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;       // words held

    logic do_wr;
    logic do_rd;

    assign in_ready  = (count != CNT_W'(DEPTH)); // low only when full
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];                // head word, combinational

    assign do_wr = in_valid && in_ready;
    assign do_rd = out_valid && out_ready;

    always_ff @(posedge ui_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // occupancy bound
    a_count_bound: assert property (@(posedge ui_clk) disable iff (rst)
        count <= CNT_W'(DEPTH));

    // head word parked while consumer stalls
    a_head_stable: assert property (@(posedge ui_clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule : stream_fifo

`default_nettype wire

/* stream_pkg.sv */
`default_nettype none

package stream_pkg;

    ////////////////////////////////////////////////////////////
    // adc side
    ////////////////////////////////////////////////////////////

    localparam int SAMPLE_BITS   = 14; // significant bits per channel
    localparam int ADC_WORD_BITS = 16; // channel port width

    ////////////////////////////////////////////////////////////
    // usb and memory words
    ////////////////////////////////////////////////////////////

    localparam int USB_WORD_BITS = 32; // ft601 bus, also stream word
    localparam int USB_BE_BITS   = USB_WORD_BITS / 8; // one enable per byte

    localparam int LANES         = 4; // 32-bit words per memory word
    localparam int LANE_BITS     = $clog2(LANES);
    localparam int MEM_WORD_BITS = LANES * USB_WORD_BITS; // 128

    // buffer depths
    localparam int IN_FIFO_DEPTH  = 16; // input and output word fifos
    localparam int MEM_FIFO_DEPTH = 8;  // stand-in for the ddr3 vfifo

    typedef logic [USB_WORD_BITS-1:0] usb_word_t;
    typedef logic [MEM_WORD_BITS-1:0] mem_word_t;

    // ft601 write side
    typedef enum logic {
        TX_IDLE,  // nothing held
        TX_WRITE  // word parked on the bus
    } tx_state_t;

endpackage : stream_pkg

`default_nettype wire

/* tb_afe_ft601.sv */
`default_nettype none

module tb_afe_ft601;

    localparam int READY_TIMEOUT = 400;  // cycles for one sample to be taken
    localparam int FILL_LIMIT    = 200;  // samples offered while txe_n is held
    localparam int DRAIN_TIMEOUT = 5000; // cycles to empty the scoreboard

    logic        ui_clk;
    logic        rst;
    logic        adc_valid;
    logic [15:0] adc_ch0;
    logic [15:0] adc_ch1;
    logic        adc_ready;
    logic        usb_txe_n;
    logic [31:0] usb_data;
    logic [3:0]  usb_be;
    logic        usb_wr_n;

    logic [31:0] expect_q[$]; // words still owed by the DUT
    int          stall_q[$];  // txe_n high cycles, used in turn
    int          stall_idx;
    int          stall_left;
    logic        hold_txe;    // device full, txe_n stuck high
    logic        txe_next;    // txe_n for the coming cycle
    string       case_name;
    int          case_words;  // transfers seen in the current case
    int          value_errors;
    int          timeout_errors;
    int          other_errors;

    afe_ft601_top UUT (
        .ui_clk(ui_clk), .rst(rst),
        .adc_valid(adc_valid), .adc_ch0(adc_ch0), .adc_ch1(adc_ch1), .adc_ready(adc_ready),
        .usb_txe_n(usb_txe_n), .usb_data(usb_data), .usb_be(usb_be), .usb_wr_n(usb_wr_n)
    );

    initial begin
        ui_clk = 1'b0;
        forever #4 ui_clk = ~ui_clk;
    end

    // ch1 in the high half, ch0 in the low half, two zero bits above each
    function automatic logic [31:0] format_sample(input logic [15:0] c0, input logic [15:0] c1);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = {16'h0000, c1 & 16'h3fff};
        lo = {16'h0000, c0 & 16'h3fff};
        return (hi << 16) | lo;
    endfunction

    function automatic int next_stall();
        int n;
        n = 0;
        if (stall_q.size() > 0) begin
            n = stall_q[stall_idx % stall_q.size()]; // pattern wraps around
            stall_idx++;
        end
        return n;
    endfunction

    ////////////////////////////////////////////////////////////
    // ft601 device model and bus monitor
    ////////////////////////////////////////////////////////////

    task automatic check_word();
        logic [31:0] exp;
        assert (usb_txe_n == 1'b0) else begin
            $display("usb_wr_n went low while usb_txe_n was high in case %s", case_name);
            other_errors++;
        end
        assert (usb_be == 4'hf) else begin
            $display("FAIL %s byte enables: expected f actual %h", case_name, usb_be);
            value_errors++;
        end
        assert (expect_q.size() > 0) else begin
            $display("word %h left the DUT with none pending in case %s", usb_data, case_name);
            other_errors++;
        end
        if (expect_q.size() > 0) begin
            exp = expect_q.pop_front();
            assert (usb_data == exp) else begin
                $display("FAIL %s: expected %h actual %h", case_name, exp, usb_data);
                value_errors++;
            end
        end
        case_words++;
    endtask

    initial begin : bus_side
        usb_txe_n = 1'b1;
        txe_next  = 1'b0;
        forever begin
            @(negedge ui_clk);
            usb_txe_n = txe_next;
            #1; // bus settled until the next rising edge
            if (!usb_wr_n) begin
                check_word();              // moves on the coming edge
                stall_left = next_stall();
            end else begin
                assert (usb_be == 4'h0) else begin
                    $display("byte enables %h active while usb_wr_n is high", usb_be);
                    other_errors++;
                end
            end
            if (hold_txe) begin
                txe_next = 1'b1;
            end else if (stall_left > 0) begin
                txe_next = 1'b1;
                stall_left--;
            end else begin
                txe_next = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // adc side, called and left on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic send_sample(input logic [15:0] c0, input logic [15:0] c1);
        int waited;
        waited    = 0;
        adc_valid = 1'b1;
        adc_ch0   = c0;
        adc_ch1   = c1;
        while (!adc_ready && waited < READY_TIMEOUT) begin
            @(negedge ui_clk);
            waited++;
        end
        assert (adc_ready) else begin
            $display("adc_ready stayed low for %0d cycles in case %s", waited, case_name);
            timeout_errors++;
        end
        if (adc_ready) expect_q.push_back(format_sample(c0, c1));
        @(negedge ui_clk); // taken on the rising edge in between
        adc_valid = 1'b0;
    endtask

    task automatic fill_until_full();
        int offered;
        offered = 0;
        while (adc_ready && offered < FILL_LIMIT) begin
            send_sample(16'($urandom), 16'($urandom)); // upper bits random too
            offered++;
        end
        assert (!adc_ready) else begin
            $display("adc_ready still high after %0d samples with txe_n held", offered);
            timeout_errors++;
        end
    endtask

    task automatic drain_words();
        int waited;
        waited = 0;
        while (expect_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge ui_clk);
            waited++;
        end
        assert (expect_q.size() == 0) else begin
            $display("%0d words never left the DUT in case %s", expect_q.size(), case_name);
            timeout_errors++;
            expect_q.delete();
        end
    endtask

    task automatic run_command(input string line);
        string       cmd;
        logic [15:0] a;
        logic [15:0] b;
        int          val;
        int          n;
        cmd = "";
        val = 0;
        n   = $sscanf(line, "%s", cmd);
        if (cmd.len() > 0 && cmd[0] != "#") begin
            if (cmd == "case") begin
                n          = $sscanf(line, "%s %s", cmd, case_name);
                case_words = 0;
                stall_q.delete(); // txe_n low unless told otherwise
                stall_idx  = 0;
                stall_left = 0;
            end else if (cmd == "s") begin
                n = $sscanf(line, "%s %h %h", cmd, a, b);
                if (n == 3) begin
                    send_sample(a, b);
                end else begin
                    $display("sample line without two channel values in case %s", case_name);
                    other_errors++;
                end
            end else if (cmd == "stall") begin
                n = $sscanf(line, "%s %d", cmd, val);
                stall_q.push_back(val);
            end else if (cmd == "rstall") begin
                n = $sscanf(line, "%s %d", cmd, val);
                stall_q.delete();
                repeat (64) stall_q.push_back(int'($urandom % (val + 1)));
            end else if (cmd == "idle") begin
                n = $sscanf(line, "%s %d", cmd, val);
                repeat (val) @(negedge ui_clk);
            end else if (cmd == "words") begin
                n = $sscanf(line, "%s %d", cmd, val);
                assert (case_words == val) else begin
                    $display("FAIL %s word count: expected %0d actual %0d",
                             case_name, val, case_words);
                    value_errors++;
                end
            end else if (cmd == "hold") begin
                hold_txe = 1'b1;
            end else if (cmd == "release") begin
                hold_txe = 1'b0;
            end else if (cmd == "fill") begin
                fill_until_full();
            end else if (cmd == "drain") begin
                drain_words();
            end else begin
                $display("unknown command %s in the case file", cmd);
                other_errors++;
            end
        end
    endtask

    initial begin : main
        int    fd;
        int    rc;
        string line;
        void'($urandom(32'h3bb9f342));
        rst            = 1'b1;
        adc_valid      = 1'b0;
        adc_ch0        = '0;
        adc_ch1        = '0;
        hold_txe       = 1'b0;
        stall_idx      = 0;
        stall_left     = 0;
        case_name      = "reset";
        case_words     = 0;
        value_errors   = 0;
        timeout_errors = 0;
        other_errors   = 0;
        repeat (16) @(negedge ui_clk);
        rst = 1'b0;
        #1;
        assert (usb_wr_n && usb_be == 4'h0 && adc_ready) else begin
            $display("FAIL reset: expected wr_n/be/ready 1/0/1 actual %b/%h/%b",
                     usb_wr_n, usb_be, adc_ready);
            value_errors++;
        end
        @(negedge ui_clk);
        fd = $fopen("afe_ft601_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open afe_ft601_cases.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc   = $fgets(line, fd);
                if (rc > 0) begin
                    run_command(line);
                end
            end
            $fclose(fd);
        end
        $display("errors: %0d value, %0d timeout, %0d other",
                 value_errors, timeout_errors, other_errors);
        if (value_errors + timeout_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : tb_afe_ft601

`default_nettype wire
